//--- hawk_gate.f
hw/hawk_pkg.sv
hw/hawk_ovrd_table.sv
hw/hawk_stall_rd.sv
hw/hawk_stall_wr.sv
hw/hawk_access_mon.sv
hw/hawk_gate_top.sv
tests/hawk_gate_checker.sv
tests/hawk_gate_tb.sv

//--- hw/hawk_access_mon.sv
// Access monitor. Counts grants and denials from both gates, each counted one
// cycle after its strobe, and raises a sticky alert once denials reach
// DENY_LIMIT. The alert stays up until reset.
`timescale 1ns/1ps
`default_nettype none

module hawk_access_mon #(
   parameter int unsigned DENY_LIMIT = 4          // denials before alert
) (
   input  wire              clk_i,
   input  wire              rst_n_i,
   input  wire              rd_grant_i,
   input  wire              rd_deny_i,
   input  wire              wr_grant_i,
   input  wire              wr_deny_i,
   output hawk_pkg::cnt_t   grant_cnt_o,
   output hawk_pkg::cnt_t   deny_cnt_o,
   output logic             alert_o
);

   logic [1:0]     grant_inc;                      // 0, 1 or 2 per cycle
   logic [1:0]     deny_inc;
   hawk_pkg::cnt_t grant_nxt;
   hawk_pkg::cnt_t deny_nxt;

   ////////////////////////////////////////////////////////////////////////////
   // event merge
   ////////////////////////////////////////////////////////////////////////////
   assign grant_inc = {1'b0, rd_grant_i} + {1'b0, wr_grant_i};
   assign deny_inc  = {1'b0, rd_deny_i} + {1'b0, wr_deny_i};
   assign grant_nxt = grant_cnt_o + hawk_pkg::cnt_t'(grant_inc); // wraps
   assign deny_nxt  = deny_cnt_o + hawk_pkg::cnt_t'(deny_inc);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         grant_cnt_o <= '0;
         deny_cnt_o  <= '0;
         alert_o     <= 1'b0;
      end else begin
         grant_cnt_o <= grant_nxt;
         deny_cnt_o  <= deny_nxt;
         // judged on the next count so alert rises with it
         if (deny_nxt >= hawk_pkg::cnt_t'(DENY_LIMIT)) begin
            alert_o <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- hw/hawk_gate_top.sv
// Top level of the cpu request gating. Connects the read and write gates to
// the shared page override table and feeds both outcomes to the access
// monitor. The mc valid of each gate is its grant event.
`timescale 1ns/1ps
`default_nettype none

module hawk_gate_top #(
   parameter int unsigned DENY_LIMIT = 4
) (
   input  wire                  clk_i,
   input  wire                  rst_n_i,
   input  wire                  boot_en_i,
   input  wire                  hawk_inactive_i,
   // table programming
   input  wire                  prog_vld_i,
   input  hawk_pkg::page_idx_t  prog_idx_i,
   input  hawk_pkg::ppa_t       prog_ppa_i,
   input  wire                  prog_allow_i,
   // cpu requests
   input  wire                  cpu_rd_vld_i,
   input  hawk_pkg::addr_t      cpu_rd_addr_i,
   input  wire                  cpu_aw_vld_i,
   input  hawk_pkg::addr_t      cpu_aw_addr_i,
   input  wire                  cpu_w_vld_i,
   input  hawk_pkg::data_t      cpu_w_data_i,
   // memory controller requests and outcomes
   output logic                 mc_rd_vld_o,
   output hawk_pkg::addr_t      mc_rd_addr_o,
   output logic                 rd_deny_o,
   output logic                 mc_wr_vld_o,
   output hawk_pkg::addr_t      mc_wr_addr_o,
   output hawk_pkg::data_t      mc_wr_data_o,
   output logic                 wr_deny_o,
   // monitor
   output hawk_pkg::cnt_t       grant_cnt_o,
   output hawk_pkg::cnt_t       deny_cnt_o,
   output logic                 alert_o
);

   hawk_pkg::page_idx_t rd_lkup_idx, wr_lkup_idx;
   hawk_pkg::ppa_t      rd_lkup_ppa, wr_lkup_ppa;
   logic                rd_lkup_allow, wr_lkup_allow;

   ////////////////////////////////////////////////////////////////////////////
   // blocks
   ////////////////////////////////////////////////////////////////////////////
   hawk_ovrd_table u_ovrd_table (
      .clk_i, .rst_n_i, .prog_vld_i, .prog_idx_i, .prog_ppa_i, .prog_allow_i,
      .rd_lkup_idx_i(rd_lkup_idx), .rd_lkup_ppa_o(rd_lkup_ppa),
      .rd_lkup_allow_o(rd_lkup_allow),
      .wr_lkup_idx_i(wr_lkup_idx), .wr_lkup_ppa_o(wr_lkup_ppa),
      .wr_lkup_allow_o(wr_lkup_allow)
   );

   hawk_stall_rd u_stall_rd (
      .clk_i, .rst_n_i, .boot_en_i, .hawk_inactive_i, .cpu_rd_vld_i, .cpu_rd_addr_i,
      .lkup_idx_o(rd_lkup_idx), .lkup_ppa_i(rd_lkup_ppa), .lkup_allow_i(rd_lkup_allow),
      .mc_rd_vld_o, .mc_rd_addr_o, .rd_deny_o
   );

   hawk_stall_wr u_stall_wr (
      .clk_i, .rst_n_i, .boot_en_i, .hawk_inactive_i,
      .cpu_aw_vld_i, .cpu_aw_addr_i, .cpu_w_vld_i, .cpu_w_data_i,
      .lkup_idx_o(wr_lkup_idx), .lkup_ppa_i(wr_lkup_ppa), .lkup_allow_i(wr_lkup_allow),
      .mc_wr_vld_o, .mc_wr_addr_o, .mc_wr_data_o, .wr_deny_o
   );

   hawk_access_mon #(.DENY_LIMIT(DENY_LIMIT)) u_access_mon (
      .clk_i, .rst_n_i,
      .rd_grant_i(mc_rd_vld_o), .rd_deny_i(rd_deny_o),   // grant is the mc strobe
      .wr_grant_i(mc_wr_vld_o), .wr_deny_i(wr_deny_o),
      .grant_cnt_o, .deny_cnt_o, .alert_o
   );

endmodule

`default_nettype wire

//--- hw/hawk_ovrd_table.sv
// Page override table. One program port writes a record (ppa plus allow bit),
// two independent combinational lookup ports serve the read and write gates.
// A written record is seen by lookups from the following cycle.
`timescale 1ns/1ps
`default_nettype none

module hawk_ovrd_table (
   input  wire                  clk_i,
   input  wire                  rst_n_i,
   // program port
   input  wire                  prog_vld_i,
   input  hawk_pkg::page_idx_t  prog_idx_i,
   input  hawk_pkg::ppa_t       prog_ppa_i,
   input  wire                  prog_allow_i,
   // read gate lookup
   input  hawk_pkg::page_idx_t  rd_lkup_idx_i,
   output hawk_pkg::ppa_t       rd_lkup_ppa_o,
   output logic                 rd_lkup_allow_o,
   // write gate lookup
   input  hawk_pkg::page_idx_t  wr_lkup_idx_i,
   output hawk_pkg::ppa_t       wr_lkup_ppa_o,
   output logic                 wr_lkup_allow_o
);

   localparam int ENTRIES = 2 ** hawk_pkg::PAGE_IDX_W;

   hawk_pkg::ppa_t ppa_q [ENTRIES];                // override page per entry
   logic           allow_q [ENTRIES];              // access permitted

   ////////////////////////////////////////////////////////////////////////////
   // record storage
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < ENTRIES; i++) begin
            ppa_q[i]   <= '0;                      // nothing mapped
            allow_q[i] <= 1'b0;                    // everything forbidden
         end
      end else if (prog_vld_i) begin
         ppa_q[prog_idx_i]   <= prog_ppa_i;
         allow_q[prog_idx_i] <= prog_allow_i;
      end
   end

   // lookups, same cycle as the request
   always_comb begin
      rd_lkup_ppa_o   = ppa_q[rd_lkup_idx_i];
      rd_lkup_allow_o = allow_q[rd_lkup_idx_i];
      wr_lkup_ppa_o   = ppa_q[wr_lkup_idx_i];
      wr_lkup_allow_o = allow_q[wr_lkup_idx_i];
   end

endmodule

`default_nettype wire

//--- hw/hawk_pkg.sv
// Shared widths, types and address helpers for the Hawk request gating blocks.
// Every block refers to these through scoped names, hawk_pkg::name.
`default_nettype none

package hawk_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // widths
   ////////////////////////////////////////////////////////////////////////////
   localparam int ADDR_W     = 32;                 // cpu and mc address
   localparam int PAGE_SHIFT = 12;                 // 4 KiB pages
   localparam int PAGE_IDX_W = 4;                  // 16 override records
   localparam int DATA_W     = 32;                 // write data
   localparam int CNT_W      = 16;                 // event counters, wrap
   localparam int PPA_W      = ADDR_W - PAGE_SHIFT; // physical page number

   localparam logic [ADDR_W-1:0] DRAM_BASE = 32'h8000_0000; // cpu view of dram start

   typedef logic [ADDR_W-1:0]     addr_t;
   typedef logic [PPA_W-1:0]      ppa_t;
   typedef logic [PAGE_IDX_W-1:0] page_idx_t;
   typedef logic [DATA_W-1:0]     data_t;
   typedef logic [CNT_W-1:0]      cnt_t;

   typedef enum logic {
      WR_IDLE,                                     // waiting for an address strobe
      WR_WAIT_DATA                                 // decision held, waiting for data
   } wr_state_t;

   ////////////////////////////////////////////////////////////////////////////
   // address rule, common to the read and the write gate
   ////////////////////////////////////////////////////////////////////////////

   // boot mode sees raw addresses, otherwise dram is moved down to zero
   function automatic addr_t rebase_addr(input addr_t addr, input logic boot_en);
      return boot_en ? addr : addr - DRAM_BASE;
   endfunction

   function automatic page_idx_t page_of(input addr_t addr);
      return addr[PAGE_SHIFT +: PAGE_IDX_W];       // bits just above the offset
   endfunction

   // swap in the override page, keep the offset
   function automatic addr_t xlate_addr(input addr_t addr, input ppa_t ppa,
                                        input logic inactive);
      return inactive ? addr : {ppa, addr[PAGE_SHIFT-1:0]};
   endfunction

endpackage

`default_nettype wire

//--- hw/hawk_stall_rd.sv
// Read request gate. Rebases the cpu address, looks the page up in the
// override table in the same cycle and, one cycle after the strobe, issues
// either the translated read to the memory controller or a deny strobe.
// Fully pipelined, one request per cycle.
`timescale 1ns/1ps
`default_nettype none

module hawk_stall_rd (
   input  wire                  clk_i,
   input  wire                  rst_n_i,
   input  wire                  boot_en_i,         // raw addresses, no rebase
   input  wire                  hawk_inactive_i,   // bypass the table
   // cpu side
   input  wire                  cpu_rd_vld_i,
   input  hawk_pkg::addr_t      cpu_rd_addr_i,
   // table lookup
   output hawk_pkg::page_idx_t  lkup_idx_o,
   input  hawk_pkg::ppa_t       lkup_ppa_i,
   input  wire                  lkup_allow_i,
   // memory controller side
   output logic                 mc_rd_vld_o,
   output hawk_pkg::addr_t      mc_rd_addr_o,
   output logic                 rd_deny_o
);

   hawk_pkg::addr_t rd_rebased;                    // address after dram rebase
   hawk_pkg::addr_t rd_xlated;                     // address after page override
   logic            rd_grant;

   ////////////////////////////////////////////////////////////////////////////
   // same cycle decision
   ////////////////////////////////////////////////////////////////////////////
   assign rd_rebased = hawk_pkg::rebase_addr(cpu_rd_addr_i, boot_en_i);
   assign lkup_idx_o = hawk_pkg::page_of(rd_rebased);
   assign rd_xlated  = hawk_pkg::xlate_addr(rd_rebased, lkup_ppa_i, hawk_inactive_i);
   assign rd_grant   = hawk_inactive_i | lkup_allow_i; // inactive never blocks

   // outcome strobes, exactly one per request
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         mc_rd_vld_o <= 1'b0;
         rd_deny_o   <= 1'b0;
      end else begin
         mc_rd_vld_o <= cpu_rd_vld_i & rd_grant;
         rd_deny_o   <= cpu_rd_vld_i & ~rd_grant;
      end
   end

   // address payload, only loaded on a grant
   always_ff @(posedge clk_i) begin
      if (cpu_rd_vld_i && rd_grant) begin
         mc_rd_addr_o <= rd_xlated;
      end
   end

endmodule

`default_nettype wire

//--- hw/hawk_stall_wr.sv
// Write request gate. The address strobe is translated and judged against
// the override table when it arrives, the decision waits for the data strobe.
// One cycle after the data strobe the combined write goes to the memory
// controller, or a deny strobe is raised instead.
`timescale 1ns/1ps
`default_nettype none

module hawk_stall_wr (
   input  wire                  clk_i,
   input  wire                  rst_n_i,
   input  wire                  boot_en_i,
   input  wire                  hawk_inactive_i,
   // cpu side
   input  wire                  cpu_aw_vld_i,
   input  hawk_pkg::addr_t      cpu_aw_addr_i,
   input  wire                  cpu_w_vld_i,
   input  hawk_pkg::data_t      cpu_w_data_i,
   // table lookup
   output hawk_pkg::page_idx_t  lkup_idx_o,
   input  hawk_pkg::ppa_t       lkup_ppa_i,
   input  wire                  lkup_allow_i,
   // memory controller side
   output logic                 mc_wr_vld_o,
   output hawk_pkg::addr_t      mc_wr_addr_o,
   output hawk_pkg::data_t      mc_wr_data_o,
   output logic                 wr_deny_o
);

   hawk_pkg::wr_state_t state_q;
   hawk_pkg::addr_t     aw_rebased;
   hawk_pkg::addr_t     aw_addr_q;                 // translated, held until data
   logic                aw_grant_q;                // decision taken at aw time
   logic                aw_take;                   // address accepted this cycle
   logic                w_take;                    // data completes the pair

   assign aw_rebased = hawk_pkg::rebase_addr(cpu_aw_addr_i, boot_en_i);
   assign lkup_idx_o = hawk_pkg::page_of(aw_rebased);

   assign aw_take = cpu_aw_vld_i && (state_q == hawk_pkg::WR_IDLE);
   assign w_take  = cpu_w_vld_i && (state_q == hawk_pkg::WR_WAIT_DATA);

   ////////////////////////////////////////////////////////////////////////////
   // aw/w pairing fsm
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q     <= hawk_pkg::WR_IDLE;
         aw_grant_q  <= 1'b0;
         mc_wr_vld_o <= 1'b0;
         wr_deny_o   <= 1'b0;
      end else begin
         mc_wr_vld_o <= w_take & aw_grant_q;
         wr_deny_o   <= w_take & ~aw_grant_q;
         if (aw_take) begin                        // data in this cycle is dropped
            aw_grant_q <= hawk_inactive_i | lkup_allow_i;
            state_q    <= hawk_pkg::WR_WAIT_DATA;
         end else if (w_take) begin
            state_q    <= hawk_pkg::WR_IDLE;       // stray aw here is ignored
         end
      end
   end

   // payload
   always_ff @(posedge clk_i) begin
      if (aw_take) begin
         aw_addr_q <= hawk_pkg::xlate_addr(aw_rebased, lkup_ppa_i, hawk_inactive_i);
      end
      if (w_take) begin
         mc_wr_data_o <= cpu_w_data_i;
      end
   end

   // held since aw, next aw lands one cycle after the write issues at earliest
   assign mc_wr_addr_o = aw_addr_q;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the hawk_gate testbench with verilator from the project root
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
      --top-module hawk_gate_tb -o hawk_gate_sim -f hawk_gate.f; then
   echo "verilator build failed"
   exit 1
fi

if ! out=$(./obj_dir/hawk_gate_sim); then
   printf '%s\n' "$out"
   echo "simulation exited with an error"
   exit 1
fi
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Regression passed"; then
   exit 0
fi
exit 1

//--- tests/hawk_gate_checker.sv
// Concurrent assertions on the gating top level, bound into hawk_gate_top.
// Covers outcome exclusivity, the sticky alert and quiet outputs after reset.
`timescale 1ns/1ps
`default_nettype none

module hawk_gate_checker (
   input wire clk_i,
   input wire rst_n_i,
   input wire rd_grant_i,
   input wire rd_deny_i,
   input wire wr_grant_i,
   input wire wr_deny_i,
   input wire alert_i
);

   // one outcome per request
   rd_one_outcome: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(rd_grant_i && rd_deny_i)) else $error("read gate granted and denied at once");
   wr_one_outcome: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(wr_grant_i && wr_deny_i)) else $error("write gate granted and denied at once");

   alert_sticky: assert property (@(posedge clk_i)
      rst_n_i && $past(rst_n_i) && $past(alert_i) |-> alert_i)
      else $error("alert dropped without a reset");

   // first cycle out of reset
   reset_quiet: assert property (@(posedge clk_i) rst_n_i && !$past(rst_n_i) |->
      !(rd_grant_i || rd_deny_i || wr_grant_i || wr_deny_i || alert_i))
      else $error("control output high right after reset");

endmodule

bind hawk_gate_top hawk_gate_checker u_checker (
   .clk_i, .rst_n_i,
   .rd_grant_i(mc_rd_vld_o), .rd_deny_i(rd_deny_o),
   .wr_grant_i(mc_wr_vld_o), .wr_deny_i(wr_deny_o),
   .alert_i(alert_o)
);

`default_nettype wire

//--- tests/hawk_gate_tb.sv
// Trace driven testbench for the Hawk request gating top level. Each trace
// line is one operation, driven on a rising edge and checked one cycle later.
// Run from the project root so the trace path resolves.
`timescale 1ns/1ps
`default_nettype none

module hawk_gate_tb;

   localparam int MAX_LINES = 64;                  // 5 words per line, op a b c d

   logic                clk_i;
   logic                rst_n_i;
   logic                boot_en_i;
   logic                hawk_inactive_i;
   logic                prog_vld_i;
   hawk_pkg::page_idx_t prog_idx_i;
   hawk_pkg::ppa_t      prog_ppa_i;
   logic                prog_allow_i;
   logic                cpu_rd_vld_i;
   hawk_pkg::addr_t     cpu_rd_addr_i;
   logic                cpu_aw_vld_i;
   hawk_pkg::addr_t     cpu_aw_addr_i;
   logic                cpu_w_vld_i;
   hawk_pkg::data_t     cpu_w_data_i;
   logic                mc_rd_vld_o;
   hawk_pkg::addr_t     mc_rd_addr_o;
   logic                rd_deny_o;
   logic                mc_wr_vld_o;
   hawk_pkg::addr_t     mc_wr_addr_o;
   hawk_pkg::data_t     mc_wr_data_o;
   logic                wr_deny_o;
   hawk_pkg::cnt_t      grant_cnt_o;
   hawk_pkg::cnt_t      deny_cnt_o;
   logic                alert_o;

   logic [31:0] trace_mem [MAX_LINES*5];
   int          n_lines;
   int          errors;
   int          cycle_cnt = 0;
   int          cycle_limit = 0;                   // 0 until the trace is read

   hawk_gate_top #(.DENY_LIMIT(4)) dut (.*);

   initial begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;                  // 20 ns period
   end

   ////////////////////////////////////////////////////////////////////////////
   // compare tasks
   ////////////////////////////////////////////////////////////////////////////
   task automatic check_addr(input string name, input hawk_pkg::addr_t got,
                             input hawk_pkg::addr_t exp);
      if (got !== exp) begin
         $display("FAIL %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_data(input string name, input hawk_pkg::data_t got,
                             input hawk_pkg::data_t exp);
      if (got !== exp) begin
         $display("FAIL %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_cnt(input string name, input hawk_pkg::cnt_t got,
                            input hawk_pkg::cnt_t exp);
      if (got !== exp) begin
         $display("FAIL %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (exp && got !== 1'b1) begin               // strobe or level never came
         $display("ERROR: expected %s high, it stayed low", name);
         errors++;
      end else if (got !== exp) begin
         $display("FAIL %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // trace operations
   ////////////////////////////////////////////////////////////////////////////
   // strobes last one cycle, everything else holds
   task automatic apply_line(input int n);
      logic [31:0] op, a, b, c;
      op = trace_mem[n*5];
      a  = trace_mem[n*5+1];
      b  = trace_mem[n*5+2];
      c  = trace_mem[n*5+3];
      prog_vld_i   <= 1'b0;
      cpu_rd_vld_i <= 1'b0;
      cpu_aw_vld_i <= 1'b0;
      cpu_w_vld_i  <= 1'b0;
      case (op)
         32'h1: begin                              // mode
            boot_en_i       <= a[0];
            hawk_inactive_i <= b[0];
         end
         32'h2: begin                              // table program
            prog_vld_i   <= 1'b1;
            prog_idx_i   <= a[hawk_pkg::PAGE_IDX_W-1:0];
            prog_ppa_i   <= b[hawk_pkg::PPA_W-1:0];
            prog_allow_i <= c[0];
         end
         32'h3: begin
            cpu_rd_vld_i  <= 1'b1;
            cpu_rd_addr_i <= a;
         end
         32'h4: begin
            cpu_aw_vld_i  <= 1'b1;
            cpu_aw_addr_i <= a;
         end
         32'h5: begin
            cpu_w_vld_i  <= 1'b1;
            cpu_w_data_i <= a;
         end
         default: ;                                // idle, count check, end marker
      endcase
   endtask

   // outcome of line n is visible one cycle after it was driven
   task automatic expect_line(input int n);
      logic [31:0] op, a, b, c, d;
      op = trace_mem[n*5];
      a  = trace_mem[n*5+1];
      b  = trace_mem[n*5+2];
      c  = trace_mem[n*5+3];
      d  = trace_mem[n*5+4];
      check_bit("mc_rd_vld_o", mc_rd_vld_o, op == 32'h3 && c == 32'h1);
      check_bit("rd_deny_o", rd_deny_o, op == 32'h3 && c == 32'h0);
      check_bit("mc_wr_vld_o", mc_wr_vld_o, op == 32'h5 && c == 32'h1);
      check_bit("wr_deny_o", wr_deny_o, op == 32'h5 && c == 32'h0);
      if (op == 32'h3 && c == 32'h1) begin
         check_addr("mc_rd_addr_o", mc_rd_addr_o, d);
      end
      if (op == 32'h5 && c == 32'h1) begin
         check_addr("mc_wr_addr_o", mc_wr_addr_o, d);
         check_data("mc_wr_data_o", mc_wr_data_o, a);
      end
      if (op == 32'h6) begin                       // running totals
         check_cnt("grant_cnt_o", grant_cnt_o, a[hawk_pkg::CNT_W-1:0]);
         check_cnt("deny_cnt_o", deny_cnt_o, b[hawk_pkg::CNT_W-1:0]);
         check_bit("alert_o", alert_o, c[0]);
      end
   endtask

   // run limit, counted from time zero
   always @(posedge clk_i) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
         $display("ERROR: no verdict after %0d cycles, run stopped", cycle_cnt);
         $display("Regression failed");
         $finish;
      end
   end

   initial begin
      rst_n_i         = 1'b0;
      boot_en_i       = 1'b0;
      hawk_inactive_i = 1'b0;
      prog_vld_i      = 1'b0;
      prog_idx_i      = '0;
      prog_ppa_i      = '0;
      prog_allow_i    = 1'b0;
      cpu_rd_vld_i    = 1'b0;
      cpu_rd_addr_i   = '0;
      cpu_aw_vld_i    = 1'b0;
      cpu_aw_addr_i   = '0;
      cpu_w_vld_i     = 1'b0;
      cpu_w_data_i    = '0;
      errors          = 0;
      $readmemh("tests/hawk_gate_trace.txt", trace_mem);
      n_lines = 0;
      while (n_lines < MAX_LINES && trace_mem[n_lines*5] != 32'hf) begin
         n_lines++;
      end
      cycle_limit = 4 * n_lines + 100;
      repeat (5) @(posedge clk_i);                 // reset held 5 cycles
      rst_n_i <= 1'b1;
      for (int i = 0; i <= n_lines; i++) begin
         @(posedge clk_i);
         apply_line(i);                            // last one is the end marker
         @(negedge clk_i);
         if (i > 0) begin
            expect_line(i - 1);
         end
      end
      $display("trace lines %0d, errors %0d", n_lines, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- tests/hawk_gate_trace.txt
// columns op a b c d in hex. op 1 mode(boot,inactive) 2 prog(idx,ppa,allow) 3 read(addr,-,res,addr)
// 4 aw(addr) 5 w(data,-,res,addr) 6 counts(grants,denies,alert) f end. res 0 deny 1 grant 2 none
1 1 1 0 0
3 12345678 0 1 12345678
3 00000abc 0 1 00000abc
1 0 0 0 0
2 3 000ab 1 0
3 80003456 0 1 000ab456
3 80003ff0 0 1 000abff0
4 80003010 0 0 0
5 deadbeef 0 1 000ab010
6 5 0 0 0
3 80005000 0 0 0
4 80005004 0 0 0
5 11111111 0 0 0
3 80005abc 0 0 0
6 5 3 0 0
5 22222222 0 2 0
3 80007000 0 0 0
6 5 4 1 0
2 5 00123 1 0
3 80005abc 0 1 00123abc
4 80005004 0 0 0
5 cafef00d 0 1 00123004
6 7 4 1 0
f 0 0 0 0
